// ==== logic/rv_pkg.sv ====
package rv_pkg;

	typedef logic [31:0] word_t;    // Data, address or instruction
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_t;

	// NEVER for straight-line code, ALWAYS for JAL
	typedef enum logic [2:0] {
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU,
		BR_NEVER,
		BR_ALWAYS
	} branch_op_t;

	typedef enum logic [3:0] {
		CLS_LUI,
		CLS_AUIPC,
		CLS_JAL,
		CLS_JALR,
		CLS_BRANCH,
		CLS_OP_IMM,
		CLS_OP,
		CLS_LOAD,
		CLS_STORE,
		CLS_NOP
	} inst_class_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_MEM_WAIT,
		ST_COMMIT
	} exec_state_t;

	typedef struct packed {
		inst_class_t cls;
		alu_op_t alu_op;
		branch_op_t branch;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t imm;
		logic use_imm;    // Operand b from immediate
		logic use_pc;     // Operand a from pc
		logic we;
	} decoded_t;

	typedef struct packed {
		logic rw;         // High for write
		word_t address;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic done;       // Completion strobe, one cycle
		word_t rdata;
	} mem_rsp_t;

	localparam word_t RESET_PC = 32'h0000_0000;
	localparam word_t STACK_TOP = 32'h0001_2000;   // Initial sp

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;  // FENCE

endpackage

// ==== logic/rv_alu.sv ====
module rv_alu (
	input rv_pkg::alu_op_t i_op,
	input rv_pkg::word_t i_a,
	input rv_pkg::word_t i_b,
	input rv_pkg::branch_op_t i_branch,
	output rv_pkg::word_t o_result,
	output logic o_taken
);
	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	assign shamt = i_b[4:0];
	assign lt_signed = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	always_comb begin
		case (i_op)
			rv_pkg::ALU_ADD: o_result = i_a + i_b;
			rv_pkg::ALU_SUB: o_result = i_a - i_b;
			rv_pkg::ALU_AND: o_result = i_a & i_b;
			rv_pkg::ALU_OR: o_result = i_a | i_b;
			rv_pkg::ALU_XOR: o_result = i_a ^ i_b;
			rv_pkg::ALU_SLL: o_result = i_a << shamt;
			rv_pkg::ALU_SRL: o_result = i_a >> shamt;
			rv_pkg::ALU_SRA: o_result = $signed(i_a) >>> shamt;
			rv_pkg::ALU_SLT: o_result = {31'b0, lt_signed};
			rv_pkg::ALU_SLTU: o_result = {31'b0, lt_unsigned};
			default: o_result = i_b;   // LUI passes the immediate
		endcase
	end

	// Branch condition, independent of the ALU operation
	always_comb begin
		case (i_branch)
			rv_pkg::BR_EQ: o_taken = i_a == i_b;
			rv_pkg::BR_NE: o_taken = i_a != i_b;
			rv_pkg::BR_LT: o_taken = lt_signed;
			rv_pkg::BR_GE: o_taken = !lt_signed;
			rv_pkg::BR_LTU: o_taken = lt_unsigned;
			rv_pkg::BR_GEU: o_taken = !lt_unsigned;
			rv_pkg::BR_ALWAYS: o_taken = 1'b1;
			default: o_taken = 1'b0;
		endcase
	end

endmodule

// ==== logic/rv_decoder.sv ====
module rv_decoder (
	input rv_pkg::word_t i_instr,
	output rv_pkg::decoded_t o_dec
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;   // funct7 bit 5
	rv_pkg::word_t imm_b;
	rv_pkg::word_t imm_i;
	rv_pkg::word_t imm_j;
	rv_pkg::word_t imm_s;
	rv_pkg::word_t imm_u;

	assign opcode = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	assign alt = i_instr[30];

	assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
	assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
	assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
	assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
	assign imm_u = {i_instr[31:12], 12'b0};

	// Shared by OP and OP-IMM, sub_sra picks SUB or SRA
	function automatic rv_pkg::alu_op_t alu_from_funct(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000: alu_from_funct = sub_sra ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b001: alu_from_funct = rv_pkg::ALU_SLL;
			3'b010: alu_from_funct = rv_pkg::ALU_SLT;
			3'b011: alu_from_funct = rv_pkg::ALU_SLTU;
			3'b100: alu_from_funct = rv_pkg::ALU_XOR;
			3'b101: alu_from_funct = sub_sra ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
			3'b110: alu_from_funct = rv_pkg::ALU_OR;
			default: alu_from_funct = rv_pkg::ALU_AND;
		endcase
	endfunction

	function automatic rv_pkg::branch_op_t branch_from_funct(input logic [2:0] f3);
		case (f3)
			3'b000: branch_from_funct = rv_pkg::BR_EQ;
			3'b001: branch_from_funct = rv_pkg::BR_NE;
			3'b100: branch_from_funct = rv_pkg::BR_LT;
			3'b101: branch_from_funct = rv_pkg::BR_GE;
			3'b110: branch_from_funct = rv_pkg::BR_LTU;
			3'b111: branch_from_funct = rv_pkg::BR_GEU;
			default: branch_from_funct = rv_pkg::BR_NEVER;   // Reserved encodings
		endcase
	endfunction

	always_comb begin
		o_dec.rd = i_instr[11:7];
		o_dec.rs1 = i_instr[19:15];
		o_dec.rs2 = i_instr[24:20];
		o_dec.cls = rv_pkg::CLS_NOP;
		o_dec.alu_op = rv_pkg::ALU_ADD;
		o_dec.branch = rv_pkg::BR_NEVER;
		o_dec.imm = imm_i;
		o_dec.use_imm = 1'b1;
		o_dec.use_pc = 1'b0;
		o_dec.we = 1'b0;
		case (opcode)
			rv_pkg::OPC_LUI: begin
				o_dec.cls = rv_pkg::CLS_LUI;
				o_dec.alu_op = rv_pkg::ALU_PASS_B;
				o_dec.imm = imm_u;
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_AUIPC: begin
				o_dec.cls = rv_pkg::CLS_AUIPC;
				o_dec.imm = imm_u;
				o_dec.use_pc = 1'b1;
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_JAL: begin
				o_dec.cls = rv_pkg::CLS_JAL;
				o_dec.branch = rv_pkg::BR_ALWAYS;
				o_dec.imm = imm_j;
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_JALR: begin
				o_dec.cls = rv_pkg::CLS_JALR;   // Target is rs1 + imm from the ALU
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_BRANCH: begin
				o_dec.cls = rv_pkg::CLS_BRANCH;
				o_dec.branch = branch_from_funct(funct3);
				o_dec.imm = imm_b;
				o_dec.use_imm = 1'b0;   // Compare rs1 with rs2
			end
			rv_pkg::OPC_OP_IMM: begin
				o_dec.cls = rv_pkg::CLS_OP_IMM;
				o_dec.alu_op = alu_from_funct(funct3, alt && funct3 == 3'b101);
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_OP: begin
				o_dec.cls = rv_pkg::CLS_OP;
				o_dec.alu_op = alu_from_funct(funct3, alt);
				o_dec.use_imm = 1'b0;
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_LOAD: begin
				o_dec.cls = rv_pkg::CLS_LOAD;
				o_dec.we = 1'b1;
			end
			rv_pkg::OPC_STORE: begin
				o_dec.cls = rv_pkg::CLS_STORE;
				o_dec.imm = imm_s;
			end
			rv_pkg::OPC_MISC_MEM: o_dec.cls = rv_pkg::CLS_NOP;   // Single bus, nothing to order
			default: o_dec.cls = rv_pkg::CLS_NOP;
		endcase
		if (i_instr[11:7] == 5'd0) o_dec.we = 1'b0;   // x0 stays zero
	end

endmodule

// ==== logic/rv_regfile.sv ====
module rv_regfile (
	input logic i_clock,
	input logic i_reset,
	input rv_pkg::reg_addr_t i_rs1,
	input rv_pkg::reg_addr_t i_rs2,
	output rv_pkg::word_t o_rs1_data,
	output rv_pkg::word_t o_rs2_data,
	input logic i_we,
	input rv_pkg::reg_addr_t i_rd,
	input rv_pkg::word_t i_wd
);
	rv_pkg::word_t regs [32];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= (i == 2) ? rv_pkg::STACK_TOP : '0;   // sp gets the stack top
			end
		end else if (i_we && i_rd != 5'd0) begin
			regs[i_rd] <= i_wd;
		end
	end

	// Reads are combinational, x0 forced to zero
	assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// ==== logic/rv_execute.sv ====
module rv_execute (
	input logic i_clock,
	input logic i_reset,
	input rv_pkg::word_t i_instr,
	input rv_pkg::word_t i_instr_pc,
	input logic i_start,
	output rv_pkg::mem_req_t o_data_req,
	output logic o_data_valid,
	input rv_pkg::mem_rsp_t i_rsp,
	output logic o_commit,
	output rv_pkg::word_t o_next_pc
);
	rv_pkg::exec_state_t state;
	rv_pkg::decoded_t dec;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;
	rv_pkg::word_t op_a;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_result;
	rv_pkg::word_t link_pc;   // pc + 4
	rv_pkg::word_t wd;
	logic taken;
	logic is_load;
	logic is_mem;
	logic is_jump;
	logic we;

	rv_decoder u_decoder (.i_instr(i_instr), .o_dec(dec));

	rv_regfile u_regfile (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1(dec.rs1),
		.i_rs2(dec.rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_we(we),
		.i_rd(dec.rd),
		.i_wd(wd)
	);

	rv_alu u_alu (
		.i_op(dec.alu_op),
		.i_a(op_a),
		.i_b(op_b),
		.i_branch(dec.branch),
		.o_result(alu_result),
		.o_taken(taken)
	);

	assign is_load = dec.cls == rv_pkg::CLS_LOAD;
	assign is_mem = is_load || dec.cls == rv_pkg::CLS_STORE;
	assign is_jump = dec.cls == rv_pkg::CLS_JAL || dec.cls == rv_pkg::CLS_JALR;
	assign link_pc = i_instr_pc + 32'd4;
	assign op_a = dec.use_pc ? i_instr_pc : rs1_data;
	assign op_b = dec.use_imm ? dec.imm : rs2_data;

	// Loads write on the bus completion, everything else at the end of run
	assign we = dec.we && (is_load ? (state == rv_pkg::ST_MEM_WAIT && i_rsp.done)
		: state == rv_pkg::ST_RUN);
	assign wd = is_load ? i_rsp.rdata : (is_jump ? link_pc : alu_result);

	// Taken by the bus unit at the end of run
	assign o_data_valid = is_mem && (state == rv_pkg::ST_RUN || state == rv_pkg::ST_MEM_WAIT);
	always_comb begin
		o_data_req.rw = dec.cls == rv_pkg::CLS_STORE;
		o_data_req.address = alu_result;   // rs1 + imm
		o_data_req.wdata = rs2_data;
	end

	assign o_commit = state == rv_pkg::ST_COMMIT;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= rv_pkg::ST_IDLE;
		end else begin
			case (state)
				rv_pkg::ST_IDLE: if (i_start) state <= rv_pkg::ST_RUN;
				rv_pkg::ST_RUN: state <= is_mem ? rv_pkg::ST_MEM_WAIT : rv_pkg::ST_COMMIT;
				rv_pkg::ST_MEM_WAIT: if (i_rsp.done) state <= rv_pkg::ST_COMMIT;
				default: state <= rv_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == rv_pkg::ST_RUN) begin
			if (dec.cls == rv_pkg::CLS_JALR) o_next_pc <= {alu_result[31:1], 1'b0};
			else if (taken) o_next_pc <= i_instr_pc + dec.imm;   // Branch or JAL
			else o_next_pc <= link_pc;
		end
	end

endmodule

// ==== logic/rv_fetch.sv ====
module rv_fetch (
	input logic i_clock,
	input logic i_reset,
	output rv_pkg::mem_req_t o_fetch_req,
	output logic o_fetch_valid,
	input rv_pkg::mem_rsp_t i_rsp,
	output rv_pkg::word_t o_instr,
	output rv_pkg::word_t o_instr_pc,
	output logic o_start,
	input logic i_commit,
	input rv_pkg::word_t i_next_pc,
	output rv_pkg::word_t o_pc,
	output logic o_retire
);
	logic fetching;   // Instruction read pending or in flight

	// On commit the next pc goes straight to the bus, saving a cycle
	assign o_fetch_valid = fetching | i_commit;
	assign o_instr_pc = o_pc;

	always_comb begin
		o_fetch_req.rw = 1'b0;
		o_fetch_req.address = i_commit ? i_next_pc : o_pc;
		o_fetch_req.wdata = '0;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_pc <= rv_pkg::RESET_PC;
			fetching <= 1'b1;      // First read right after reset
			o_start <= 1'b0;
			o_retire <= 1'b0;
		end else begin
			o_start <= 1'b0;
			o_retire <= 1'b0;
			if (fetching && i_rsp.done) begin
				fetching <= 1'b0;
				o_start <= 1'b1;
			end
			if (i_commit) begin
				o_pc <= i_next_pc;
				o_retire <= 1'b1;
				fetching <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (fetching && i_rsp.done) o_instr <= i_rsp.rdata;
	end

endmodule

// ==== logic/rv_mem_access.sv ====
module rv_mem_access (
	input logic i_clock,
	input logic i_reset,
	input rv_pkg::mem_req_t i_fetch_req,
	input logic i_fetch_valid,
	input rv_pkg::mem_req_t i_data_req,
	input logic i_data_valid,
	output rv_pkg::mem_rsp_t o_fetch_rsp,
	output rv_pkg::mem_rsp_t o_data_rsp,
	output logic o_request,
	output logic o_rw,
	output rv_pkg::word_t o_address,
	output rv_pkg::word_t o_data,
	input logic i_ready,
	input rv_pkg::word_t i_data
);
	rv_pkg::mem_req_t sel_req;
	logic accept;
	logic complete;
	logic owner_data;   // Access on the bus belongs to execute

	// Fetch and execute never request together
	assign sel_req = i_data_valid ? i_data_req : i_fetch_req;
	assign accept = !o_request && (i_fetch_valid || i_data_valid);
	assign complete = o_request && i_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_request <= 1'b0;
			o_rw <= 1'b0;
			owner_data <= 1'b0;
		end else if (accept) begin
			o_request <= 1'b1;
			o_rw <= sel_req.rw;
			owner_data <= i_data_valid;
		end else if (complete) begin
			o_request <= 1'b0;   // Drops the cycle after ready
			o_rw <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_address <= sel_req.address;
			o_data <= sel_req.wdata;
		end
	end

	// Completion goes back to whoever owns the access
	always_comb begin
		o_fetch_rsp.done = complete && !owner_data;
		o_fetch_rsp.rdata = i_data;
		o_data_rsp.done = complete && owner_data;
		o_data_rsp.rdata = i_data;
	end

endmodule

// ==== logic/rv_core.sv ====
module rv_core (
	input logic i_clock,
	input logic i_reset,
	output logic o_request,
	output logic o_rw,
	output rv_pkg::word_t o_address,
	output rv_pkg::word_t o_data,
	input logic i_ready,
	input rv_pkg::word_t i_data,
	output rv_pkg::word_t o_pc,
	output logic o_retire
);
	rv_pkg::mem_req_t fetch_req;
	rv_pkg::mem_req_t data_req;
	rv_pkg::mem_rsp_t fetch_rsp;
	rv_pkg::mem_rsp_t data_rsp;
	logic fetch_valid;
	logic data_valid;
	rv_pkg::word_t instr;
	rv_pkg::word_t instr_pc;
	logic start;
	logic commit;
	rv_pkg::word_t next_pc;

	rv_fetch u_fetch (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_fetch_req(fetch_req),
		.o_fetch_valid(fetch_valid),
		.i_rsp(fetch_rsp),
		.o_instr(instr),
		.o_instr_pc(instr_pc),
		.o_start(start),
		.i_commit(commit),
		.i_next_pc(next_pc),
		.o_pc(o_pc),
		.o_retire(o_retire)
	);

	rv_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr(instr),
		.i_instr_pc(instr_pc),
		.i_start(start),
		.o_data_req(data_req),
		.o_data_valid(data_valid),
		.i_rsp(data_rsp),
		.o_commit(commit),
		.o_next_pc(next_pc)
	);

	// Only bus master
	rv_mem_access u_mem_access (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_req(fetch_req),
		.i_fetch_valid(fetch_valid),
		.i_data_req(data_req),
		.i_data_valid(data_valid),
		.o_fetch_rsp(fetch_rsp),
		.o_data_rsp(data_rsp),
		.o_request(o_request),
		.o_rw(o_rw),
		.o_address(o_address),
		.o_data(o_data),
		.i_ready(i_ready),
		.i_data(i_data)
	);

endmodule

// ==== dv/rv_core_assertions.sv ====
module rv_core_assertions (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input logic i_rw,
	input rv_pkg::word_t i_address,
	input rv_pkg::word_t i_data,
	input logic i_ready,
	input rv_pkg::word_t i_pc,
	input logic i_retire
);
	int fail_count = 0;

	// Bus stays quiet while reset is applied
	reset_quiet: assert property (@(posedge i_clock)
		$past(i_reset) |-> !i_request && !i_rw && !i_retire)
		else begin
			fail_count++;
			$error("Bus or retire active during reset");
		end

	first_fetch: assert property (@(posedge i_clock)
		$past(i_reset, 2) && !$past(i_reset) |-> i_request && !i_rw && i_address == '0)
		else begin
			fail_count++;
			$error("First request after reset is not a read of address zero");
		end

	hold_until_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_request && !i_ready |=> i_request && $stable(i_address) && $stable(i_rw)
			&& $stable(i_data))
		else begin
			fail_count++;
			$error("Request changed while waiting for ready");
		end

	drop_after_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_request && i_ready |=> !i_request)
		else begin
			fail_count++;
			$error("Request still high the cycle after ready");
		end

	// Next fetch goes out with the retire pulse
	fetch_at_pc: assert property (@(posedge i_clock) disable iff (i_reset)
		i_retire |-> i_request && !i_rw && i_address == i_pc && i_address[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("Fetch after retire is not an aligned read at the new pc");
		end

endmodule

// ==== dv/rv_core_tb.sv ====
module rv_core_tb;

	localparam int MEM_WORDS = 256;
	localparam int SIG_BASE = 'h200;   // Signature region of one word per result
	localparam int SIG_WORDS = 14;
	localparam int SKIP_ADDR = 'h280;  // Only code that must be skipped stores here
	localparam int PROG_WORDS = 69;
	localparam int WORST_CYCLES = 16;  // Fetch and data access at 3 wait cycles each
	localparam int TIMEOUT_CYCLES = PROG_WORDS * WORST_CYCLES + 8;

	logic i_clock;
	logic i_reset;
	logic o_request;
	logic o_rw;
	rv_pkg::word_t o_address;
	rv_pkg::word_t o_data;
	logic i_ready;
	rv_pkg::word_t i_data;
	rv_pkg::word_t o_pc;
	logic o_retire;

	rv_pkg::word_t mem [MEM_WORDS];
	rv_pkg::word_t expected [SIG_WORDS];
	logic written [SIG_WORDS];
	logic [15:0] lfsr;
	int wait_left;
	logic waiting;
	int prog_len;
	int data_errors;
	int cycles;
	logic done;
	rv_pkg::word_t last_pc;

	rv_core u_dut (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.o_request(o_request),
		.o_rw(o_rw),
		.o_address(o_address),
		.o_data(o_data),
		.i_ready(i_ready),
		.i_data(i_data),
		.o_pc(o_pc),
		.o_retire(o_retire)
	);

	bind rv_core rv_core_assertions u_assertions (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(o_request),
		.i_rw(o_rw),
		.i_address(o_address),
		.i_data(o_data),
		.i_ready(i_ready),
		.i_pc(o_pc),
		.i_retire(o_retire)
	);

	always #10 i_clock = ~i_clock;

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		r_type = {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		i_type = {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2);
		s_type = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};   // sw rs2, imm(x0)
	endfunction

	function automatic rv_pkg::word_t b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [12:0] off;
		off = 13'd8;   // Always skips exactly one instruction
		b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
		j_type = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic place(input rv_pkg::word_t instr);
		mem[prog_len] = instr;
		prog_len++;
	endtask

	task automatic place_branch_pair(input logic [2:0] f3, input logic [4:0] a,
		input logic [4:0] b);
		place(b_type(f3, a, b));                  // Taken
		place(s_type(SKIP_ADDR[11:0], 5'd20));
		place(b_type(f3 ^ 3'b001, a, b));         // Opposite condition falls through
		place(i_type(12'd1, 5'd22, 3'b000, 5'd22, 7'b0010011));
	endtask

	task automatic load_program();
		for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'h5A5A_5A5A ^ (i << 2);
		prog_len = 0;
		place(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011));       // x1 = 5
		place(i_type(12'hFFD, 5'd0, 3'b000, 5'd3, 7'b0010011));     // x3 = -3
		place(r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd4));             // add
		place(s_type(12'h200, 5'd4));
		place(r_type(7'h20, 5'd3, 5'd1, 3'b000, 5'd5));             // sub
		place(s_type(12'h204, 5'd5));
		place(i_type(12'h0F0, 5'd3, 3'b100, 5'd6, 7'b0010011));     // xori
		place(s_type(12'h208, 5'd6));
		place(i_type(12'd4, 5'd1, 3'b001, 5'd7, 7'b0010011));       // slli
		place(i_type(12'd28, 5'd3, 3'b101, 5'd9, 7'b0010011));      // srli
		place(r_type(7'h00, 5'd9, 5'd7, 3'b110, 5'd10));            // or
		place(s_type(12'h20C, 5'd10));
		place(i_type(12'h401, 5'd3, 3'b101, 5'd8, 7'b0010011));     // srai 1
		place(r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd11));            // sll
		place(r_type(7'h00, 5'd11, 5'd8, 3'b100, 5'd12));           // xor
		place(s_type(12'h210, 5'd12));
		place(r_type(7'h00, 5'd1, 5'd3, 3'b010, 5'd13));            // slt
		place(r_type(7'h00, 5'd1, 5'd3, 3'b011, 5'd14));            // sltu
		place(i_type(12'd6, 5'd1, 3'b011, 5'd15, 7'b0010011));      // sltiu
		place(i_type(12'd2, 5'd15, 3'b001, 5'd15, 7'b0010011));
		place(r_type(7'h00, 5'd15, 5'd13, 3'b110, 5'd13));
		place(r_type(7'h00, 5'd14, 5'd13, 3'b000, 5'd13));
		place(s_type(12'h214, 5'd13));
		place({20'h12345, 5'd16, 7'b0110111});                      // lui
		place(i_type(12'h678, 5'd16, 3'b000, 5'd16, 7'b0010011));
		place(s_type(12'h218, 5'd16));
		place({20'h00001, 5'd17, 7'b0010111});                      // auipc at 0x68
		place(s_type(12'h21C, 5'd17));
		place(i_type(12'h218, 5'd0, 3'b010, 5'd18, 7'b0000011));    // lw
		place(s_type(12'h220, 5'd18));
		place(s_type(12'h224, 5'd2));                               // sp after reset
		place(i_type(12'd7, 5'd0, 3'b000, 5'd0, 7'b0010011));       // write to x0
		place(s_type(12'h228, 5'd0));
		place(i_type(12'h7AD, 5'd0, 3'b000, 5'd20, 7'b0010011));    // Marker value
		place_branch_pair(3'b000, 5'd1, 5'd1);   // beq / bne with equal operands
		place_branch_pair(3'b001, 5'd1, 5'd3);   // bne / beq with unequal operands
		place_branch_pair(3'b100, 5'd3, 5'd1);   // blt / bge
		place_branch_pair(3'b101, 5'd1, 5'd3);   // bge / blt
		place_branch_pair(3'b110, 5'd1, 5'd3);   // bltu / bgeu
		place_branch_pair(3'b111, 5'd3, 5'd1);   // bgeu / bltu
		place(s_type(12'h22C, 5'd22));
		place(j_type(21'd12, 5'd24));            // jal over two markers
		place(s_type(SKIP_ADDR[11:0], 5'd20));
		place(s_type(SKIP_ADDR[11:0], 5'd20));
		place(s_type(12'h230, 5'd24));
		place(i_type(12'h10C, 5'd0, 3'b000, 5'd25, 7'b0010011));
		place(i_type(12'd1, 5'd25, 3'b000, 5'd26, 7'b1100111));    // jalr drops bit 0
		place(s_type(SKIP_ADDR[11:0], 5'd20));
		place(s_type(SKIP_ADDR[11:0], 5'd20));
		place(s_type(12'h234, 5'd26));
		place(j_type(21'd0, 5'd0));              // Final self-loop
		expected = '{32'h2, 32'h8, 32'hFFFF_FF0D, 32'h5F, 32'hFFFF_FF5E, 32'h5,
			32'h1234_5678, 32'h1068, 32'h1234_5678, 32'h0001_2000, 32'h0, 32'h6,
			32'hF0, 32'h104};
	endtask

	// Memory model answering after 0 to 3 wait cycles
	always @(negedge i_clock) begin
		int idx;
		if (i_ready || i_reset) begin
			i_ready = 1'b0;
		end else if (o_request) begin
			if (!waiting) begin
				wait_left = int'(lfsr[0]);
				lfsr = lfsr_next(lfsr);
				wait_left = wait_left + 2 * int'(lfsr[0]);
				lfsr = lfsr_next(lfsr);
				waiting = 1'b1;
			end
			if (wait_left == 0) begin
				waiting = 1'b0;
				i_ready = 1'b1;
				i_data = mem[o_address[9:2]];
				if (o_rw) begin
					mem[o_address[9:2]] = o_data;
					idx = (o_address - SIG_BASE) >> 2;
					if (o_address >= SIG_BASE && idx < SIG_WORDS) begin
						written[idx] = 1'b1;
						assert (o_data == expected[idx]) else begin
							$display("FAILED o_data at 0x%08h: got 0x%08h, expected 0x%08h",
								o_address, o_data, expected[idx]);
							data_errors++;
						end
					end
					assert (o_address != SKIP_ADDR) else begin
						$display("Skipped code at pc 0x%08h stored a marker", o_pc);
						data_errors++;
					end
				end
			end else begin
				wait_left--;
			end
		end
	end

	// The self-loop retires with an unchanged pc
	always @(negedge i_clock) begin
		if (!i_reset && o_retire) begin
			if (o_pc == last_pc) done = 1'b1;
			last_pc = o_pc;
		end
	end

	always @(posedge i_clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES && !done) begin
			$display("Timeout: no final loop within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int missing;
		int protocol_errors;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_ready = 1'b0;
		i_data = '0;
		lfsr = 16'd33011;
		waiting = 1'b0;
		wait_left = 0;
		data_errors = 0;
		cycles = 0;
		done = 1'b0;
		last_pc = 32'hFFFF_FFFF;
		for (int i = 0; i < SIG_WORDS; i++) written[i] = 1'b0;
		load_program();
		repeat (4) @(negedge i_clock);
		i_reset = 1'b0;
		wait (done);
		@(negedge i_clock);
		missing = 0;
		for (int i = 0; i < SIG_WORDS; i++) begin
			if (!written[i]) begin
				$display("Signature word at 0x%08h was never written", SIG_BASE + 4 * i);
				missing++;
			end
		end
		protocol_errors = u_dut.u_assertions.fail_count;
		$display("Errors: data %0d, missing %0d, protocol %0d",
			data_errors, missing, protocol_errors);
		if (data_errors + missing + protocol_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
logic/rv_pkg.sv
logic/rv_alu.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_fetch.sv
logic/rv_mem_access.sv
logic/rv_core.sv
dv/rv_core_assertions.sv
dv/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= rv_core_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
SIM_ARGS ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
